//--- common/pattern_color_pkg.sv
package pattern_color_pkg;

	import pattern_geom_pkg::*;

	typedef logic [31:0] color_t;

	// word layout follows the frame buffer's packing, not plain rgb
	localparam color_t light_gray  = 32'hc000c0c0;
	localparam color_t yellow      = 32'h0000c0c0;
	localparam color_t light_blue  = 32'hc000c000;
	localparam color_t green       = 32'h0000c000;
	localparam color_t purple      = 32'hc00000c0;
	localparam color_t red         = 32'h000000c0;
	localparam color_t blue        = 32'hc0000000;
	localparam color_t gray        = 32'h13001313;
	localparam color_t dark_blue   = 32'h4c002100;
	localparam color_t white       = 32'hff00ffff;
	localparam color_t dark_purple = 32'h6a000032;
	localparam color_t mid_gray1   = 32'h09000909;
	localparam color_t mid_gray2   = 32'h1d001d1d;

	// indexed [band][bar], bar 0 on the left
	localparam color_t band_colors [num_bands][num_bars] = '{
		'{light_gray, yellow, light_blue, green, purple, red, blue, white},
		'{blue, gray, purple, gray, light_blue, gray, light_gray, gray},
		// bar 4 here is replaced by the sub-bars below
		'{dark_blue, white, dark_purple, gray, mid_gray1, gray, light_gray, gray}
	};

	typedef struct packed {
		logic                        valid;
		logic [$clog2(num_bars)-1:0] bar;
	} split_t;

	// only the bottom band has a split bar
	localparam split_t split_bar [num_bands] = '{
		'{valid: 1'b0, bar: '0},
		'{valid: 1'b0, bar: '0},
		'{valid: 1'b1, bar: 3'd4}
	};

	// narrow bars, left to right
	localparam color_t sub_bar_colors [bar_width / sub_bar_width] = '{
		mid_gray1, gray, mid_gray2, mid_gray1
	};

endpackage

//--- common/pattern_geom_pkg.sv
package pattern_geom_pkg;

	// frame size in pixels
	localparam int img_width  = 320;
	localparam int img_height = 240;

	// every band is split into equal bars across the line
	localparam int bar_width     = 40;
	localparam int sub_bar_width = 10;
	localparam int num_bars      = 8;

	localparam int num_bands = 3;

	// one write per pixel
	localparam int pixel_count = img_width * img_height;

	// 18 bits covers a full frame from any base in the buffer
	typedef logic [17:0] addr_t;

	// row and column share one width, 9 bits holds 0..319
	typedef logic [8:0] coord_t;

	// a band runs up to the next band's first row, the last one to img_height
	localparam coord_t band_first_row [num_bands] = '{
		9'd0,
		9'd120,
		9'd180
	};

endpackage

//--- common/pixel_scan_if.sv
`timescale 1ns/1ps

interface pixel_scan_if import pattern_geom_pkg::*; ();

	// position of the pixel being emitted
	coord_t row;
	coord_t col;

	// frame-buffer word for that pixel
	addr_t  pix_addr;

	// one cycle per pixel, no back-pressure
	logic   pix_valid;

	modport source (
		output row,
		output col,
		output pix_addr,
		output pix_valid
	);

	modport painter (
		input row,
		input col
	);

	modport sink (
		input pix_addr,
		input pix_valid
	);

endinterface

//--- design/band_painter.sv
`timescale 1ns/1ps

module band_painter
	import pattern_geom_pkg::*;
	import pattern_color_pkg::*;
#(
	parameter int band_index = 0
) (
	pixel_scan_if.painter scan,
	output logic          hit,
	output color_t        color
);

	// row just past this band
	function automatic int band_end(int b);
		if (b + 1 < num_bands)
			return band_first_row[b + 1];
		return img_height;
	endfunction

	localparam int first_row = band_first_row[band_index];
	localparam int end_row   = band_end(band_index);

	logic [$clog2(num_bars)-1:0]                    bar_idx;
	coord_t                                         bar_offset;
	logic [$clog2(bar_width / sub_bar_width)-1:0]   sub_idx;
	logic                                           in_split;

	assign hit = scan.row >= coord_t'(first_row) && scan.row < coord_t'(end_row);

	assign bar_idx    = ($clog2(num_bars))'(scan.col / bar_width);
	assign bar_offset = scan.col - coord_t'(bar_idx * bar_width);
	assign sub_idx    = ($clog2(bar_width / sub_bar_width))'(bar_offset / sub_bar_width);

	assign in_split = split_bar[band_index].valid && bar_idx == split_bar[band_index].bar;

	always_comb begin
		color = band_colors[band_index][bar_idx];
		// narrow bars override the table entry
		if (in_split)
			color = sub_bar_colors[sub_idx];
	end

endmodule

//--- design/color_bar_gen.sv
`timescale 1ns/1ps

module color_bar_gen
	import pattern_geom_pkg::*;
	import pattern_color_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  logic   enable,
	input  logic   pause,
	input  addr_t  start_addr,
	output color_t data_write,
	output addr_t  addr,
	output logic   wren,
	output logic   done
);

	pixel_scan_if scan_if ();

	logic [num_bands-1:0] band_hit;
	color_t               band_color [num_bands];

	pixel_scanner scanner_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.enable     (enable),
		.pause      (pause),
		.start_addr (start_addr),
		.scan       (scan_if.source),
		.done       (done)
	);

	// one painter per band, all looking at the same pixel
	for (genvar g = 0; g < num_bands; g++) begin : gen_band
		band_painter #(
			.band_index (g)
		) painter_i (
			.scan  (scan_if.painter),
			.hit   (band_hit[g]),
			.color (band_color[g])
		);
	end

	framebuffer_writer writer_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.scan       (scan_if.sink),
		.band_hit   (band_hit),
		.band_color (band_color),
		.data_write (data_write),
		.addr       (addr),
		.wren       (wren)
	);

endmodule

//--- design/framebuffer_writer.sv
`timescale 1ns/1ps

module framebuffer_writer
	import pattern_geom_pkg::*;
	import pattern_color_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	pixel_scan_if.sink           scan,
	input  logic [num_bands-1:0] band_hit,
	input  color_t               band_color [num_bands],
	output color_t               data_write,
	output addr_t                addr,
	output logic                 wren
);

	color_t pick;

	// bands do not overlap, so at most one hit is set
	always_comb begin
		pick = '0;
		for (int b = 0; b < num_bands; b++) begin
			if (band_hit[b])
				pick = band_color[b];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wren       <= 1'b0;
			data_write <= '0;
			addr       <= '0;
		end else begin
			wren <= scan.pix_valid;
			// data and address hold between writes
			if (scan.pix_valid) begin
				data_write <= pick;
				addr       <= scan.pix_addr;
			end
		end
	end

endmodule

//--- design/pixel_scanner.sv
`timescale 1ns/1ps

module pixel_scanner import pattern_geom_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              enable,
	input  logic              pause,
	input  addr_t             start_addr,
	pixel_scan_if.source      scan,
	output logic              done
);

	typedef enum logic [1:0] {
		st_idle,
		st_painting,
		st_finished
	} state_t;

	state_t state;

	// high in the half of the pixel slot where the strobe goes out
	logic phase;
	logic last_pixel;
	logic last_col;

	assign last_col   = scan.col == coord_t'(img_width - 1);
	assign last_pixel = last_col && scan.row == coord_t'(img_height - 1);

	// a paused cycle never carries a pixel, the strobe waits for the next free cycle
	assign scan.pix_valid = phase && !pause;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state         <= st_idle;
			phase         <= 1'b0;
			done          <= 1'b0;
			scan.row      <= '0;
			scan.col      <= '0;
			scan.pix_addr <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (enable && !pause) begin
						state         <= st_painting;
						phase         <= 1'b0;
						scan.row      <= '0;
						scan.col      <= '0;
						scan.pix_addr <= start_addr;
					end
				end
				st_painting: begin
					if (!pause) begin
						phase <= !phase;
						// pixel leaves this cycle, step to the next one
						if (phase) begin
							scan.pix_addr <= scan.pix_addr + addr_t'(1);
							if (last_col) begin
								scan.col <= '0;
								scan.row <= scan.row + coord_t'(1);
							end else begin
								scan.col <= scan.col + coord_t'(1);
							end
							// done lands together with the final write
							if (last_pixel) begin
								state <= st_finished;
								done  <= 1'b1;
							end
						end
					end
				end
				st_finished: begin
					if (!enable) begin
						state <= st_idle;
						done  <= 1'b0;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

//--- sources.f
+incdir+tb
common/pattern_geom_pkg.sv
common/pattern_color_pkg.sv
common/pixel_scan_if.sv
design/pixel_scanner.sv
design/band_painter.sv
design/framebuffer_writer.sv
design/color_bar_gen.sv
tb/color_bar_gen_tb.sv

//--- tb/pattern_model.svh
`ifndef PATTERN_MODEL_SVH
`define PATTERN_MODEL_SVH

// index counts writes within one frame, in raster order from zero
function automatic addr_t frame_addr(addr_t base, int index);
	return addr_t'(int'(base) + index);
endfunction

// full-width bar colours, left to right
function automatic color_t bar_lookup(int band, int bar);
	color_t top_row [8];
	color_t mid_row [8];
	color_t low_row [8];
	top_row = '{light_gray, yellow, light_blue, green, purple, red, blue, white};
	mid_row = '{blue, gray, purple, gray, light_blue, gray, light_gray, gray};
	// bar 4 never read here, the split rule covers it
	low_row = '{dark_blue, white, dark_purple, gray, 32'h0, gray, light_gray, gray};
	case (band)
		0: return top_row[bar];
		1: return mid_row[bar];
		default: return low_row[bar];
	endcase
endfunction

function automatic color_t narrow_lookup(int sub);
	case (sub)
		0: return mid_gray1;
		1: return gray;
		2: return mid_gray2;
		default: return mid_gray1;
	endcase
endfunction

function automatic color_t pixel_color(int index);
	int row;
	int col;
	int band;
	int bar;
	row  = index / img_width;
	col  = index % img_width;
	band = 0;
	if (row >= band_first_row[1])
		band = 1;
	if (row >= band_first_row[2])
		band = 2;
	bar = col / bar_width;
	// bottom band, fifth bar is cut into four narrow ones
	if (band == 2 && bar == 4)
		return narrow_lookup((col % bar_width) / sub_bar_width);
	return bar_lookup(band, bar);
endfunction

`endif

//--- tb/color_bar_gen_tb.sv
`timescale 1ns/1ps

module color_bar_gen_tb
	import pattern_geom_pkg::*;
	import pattern_color_pkg::*;
();

	`include "pattern_model.svh"

	logic   clk;
	logic   arst_n;
	logic   enable;
	logic   pause;
	addr_t  start_addr;
	color_t data_write;
	addr_t  addr;
	logic   wren;
	logic   done;

	int     value_errors;
	int     timeout_errors;
	int     write_idx;
	addr_t  frame_base;
	bit     idle_expected;
	logic   prev_wren;
	logic   prev_pause;
	logic   prev_done;
	logic   prev_enable;

	color_bar_gen color_bar_gen_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.enable     (enable),
		.pause      (pause),
		.start_addr (start_addr),
		.data_write (data_write),
		.addr       (addr),
		.wren       (wren),
		.done       (done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// outputs sampled on the edge before the DUT registers update
	always @(posedge clk) begin
		if (idle_expected)
			assert (!wren && !done) else begin
				value_errors++;
				$display("error at %0t: wren=%b done=%b while idle", $time, wren, done);
			end
		if (wren) begin
			assert (!prev_wren) else begin
				value_errors++;
				$display("error at %0t: wren high on two consecutive cycles", $time);
			end
			assert (!prev_pause) else begin
				value_errors++;
				$display("error at %0t: wren high right after a paused cycle", $time);
			end
			assert (write_idx < pixel_count) else begin
				value_errors++;
				$display("error at %0t: write %0d is past the end of the frame",
					$time, write_idx);
			end
			if (write_idx < pixel_count) begin
				assert (addr == frame_addr(frame_base, write_idx)) else begin
					value_errors++;
					$display("error at %0t: write %0d addr %h, expected %h", $time,
						write_idx, addr, frame_addr(frame_base, write_idx));
				end
				assert (data_write == pixel_color(write_idx)) else begin
					value_errors++;
					$display("error at %0t: write %0d data %h, expected %h", $time,
						write_idx, data_write, pixel_color(write_idx));
				end
				// done goes up with the last write and not before
				assert (done == (write_idx == pixel_count - 1)) else begin
					value_errors++;
					$display("error at %0t: done=%b on write %0d", $time, done, write_idx);
				end
			end
			write_idx++;
		end else begin
			assert (!(done && !prev_done)) else begin
				value_errors++;
				$display("error at %0t: done rose without a write", $time);
			end
		end
		if (prev_done && prev_enable)
			assert (done) else begin
				value_errors++;
				$display("error at %0t: done dropped while enable was high", $time);
			end
		if (prev_done && !prev_enable)
			assert (!done) else begin
				value_errors++;
				$display("error at %0t: done still high after enable dropped", $time);
			end
		prev_wren   = wren;
		prev_pause  = pause;
		prev_done   = done;
		prev_enable = enable;
	end

	// random pause bursts while the frame is painted
	task automatic run_until_done(input int max_cycles, input bit with_pauses);
		int cycles;
		int burst;
		bit seen;
		cycles = 0;
		burst  = 0;
		seen   = 0;
		while (!seen && cycles < max_cycles) begin
			@(posedge clk);
			seen = done;
			#1;
			if (seen) begin
				pause = 1'b0;
			end else begin
				if (with_pauses && burst == 0 && $urandom_range(15) == 0)
					burst = $urandom_range(6, 1);
				pause = burst > 0;
				if (burst > 0)
					burst--;
			end
			cycles++;
		end
		if (!seen) begin
			timeout_errors++;
			$display("timeout: done did not rise within %0d cycles", max_cycles);
		end
	endtask

	task automatic wait_done_low(input int max_cycles);
		int cycles;
		bit cleared;
		cycles  = 0;
		cleared = 0;
		while (!cleared && cycles < max_cycles) begin
			@(posedge clk);
			cleared = !done;
			#1;
			cycles++;
		end
		if (!cleared) begin
			timeout_errors++;
			$display("timeout: done stayed high %0d cycles after enable dropped", max_cycles);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_frame(input addr_t base, input bit with_pauses);
		frame_base    = base;
		write_idx     = 0;
		idle_expected = 0;
		start_addr    = base;
		enable        = 1'b1;
		run_until_done(400000, with_pauses);
		assert (write_idx == pixel_count) else begin
			value_errors++;
			$display("error at %0t: %0d writes before done, expected %0d",
				$time, write_idx, pixel_count);
		end
		// done must stay up while enable is held
		idle_cycles(20);
		enable = 1'b0;
		wait_done_low(50);
		idle_expected = 1;
		idle_cycles(10);
	endtask

	initial begin
		void'($urandom(32'h317c5464));
		value_errors   = 0;
		timeout_errors = 0;
		write_idx      = 0;
		frame_base     = '0;
		idle_expected  = 1;
		prev_wren      = 1'b0;
		prev_pause     = 1'b0;
		prev_done      = 1'b0;
		prev_enable    = 1'b0;
		arst_n         = 1'b1;
		enable         = 1'b0;
		pause          = 1'b0;
		start_addr     = '0;

		// reset goes low on a real falling edge
		#1;
		arst_n = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		// enable still low so nothing may be written
		idle_cycles(16);

		run_frame(18'h00400, 1'b0);
		run_frame(18'h2a5c3, 1'b1);

		$display("value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
